/* build.f */
src/configure_pkg.sv
src/isa_pkg.sv
src/sequencer.sv
src/fetch_stage.sv
src/decoder.sv
src/register.sv
src/alu.sv
src/memory_stage.sv
src/cpu.sv
tb/clock_gen.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the cpu_tb simulation from the project root.
cd "$(dirname "$0")" &&
  verilator --binary --timing -f build.f --top-module cpu_tb -o cpu_tb_sim &&
  ./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "^Testbench passed$" &&
  echo "run.sh: simulation ok" ||
  { echo "run.sh: simulation not ok"; exit 1; }

/* tb/cpu_testdata.hex */
// Header: program length in words, store count.
// Then program words, then one (address, data) pair per expected store.
00000039 00000011
// ALU ops, LUI, AUIPC, immediates.
00500093 FFD00113 002081B3 40208233
401152B3 00112333 003093B3 0042D433
123454B7 00001517 0FF4C593 0F05F613
70066693 FFE12713 009447B3 00D2F833
007368B3 10302023 10402223 10502423
10602623 10702823 10802A23 10A02C23
10E02E23 12F02023 13002223 13102423
// Load round trip, x0 write, branches, JAL, JALR, end store.
10402903 13202623 05500013 00700993
13302823 00208463 00209463 00100A13
00114463 00100A13 00115463 002A0A13
0020D463 00100A13 00108463 00100A13
13402A23 00C00AEF 00100A13 00100A13
13502C23 0D400B13 000B0BE7 00100A13
00100A13 13702E23 00001C37 FF4C2E23
0000006F
// Expected stores.
00000100 00000002
00000104 00000008
00000108 FFFFFFFF
0000010C 00000001
00000110 00000014
00000114 00FFFFFF
00000118 00001024
0000011C 00000001
00000120 12CBAFFF
00000124 000007F0
00000128 00000015
0000012C 00000008
00000130 00000007
00000134 00000002
00000138 000000B8
0000013C 000000CC
00000FFC 00000002

/* tb/cpu_tb.sv */
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import configure_pkg::*;

  logic clock, rst_n;
  logic imemory_valid, imemory_instr, imemory_ready;
  logic dmemory_valid, dmemory_instr, dmemory_ready;
  addr_t imemory_addr, dmemory_addr;
  word_t imemory_wdata, imemory_rdata, dmemory_wdata, dmemory_rdata;
  strb_t imemory_wstrb, dmemory_wstrb;

  word_t testdata [0:1023];
  word_t rom [0:255];
  word_t ram [0:255];
  int prog_len, store_count, store_idx, cycles, limit;
  int value_errors, other_errors;
  logic done, first_fetch;

  clock_gen clock_gen0 (.clock (clock));

  cpu dut0 (.*);

  task automatic check_value(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      value_errors++;
      $display("[FAIL] %s got %08h expected %08h", name, got, expected);
    end
  endtask

  // Instruction ROM with a random wait before ready.
  always begin : imem_model
    int wait_cnt;
    @(posedge clock);
    #1;
    if (rst_n && imemory_valid) begin
      if (first_fetch) begin
        check_value("imemory_addr", imemory_addr, reset_vector_exp());
        first_fetch = 1'b0;
      end
      if (imemory_addr[1:0] != 2'b0 || imemory_addr >= prog_len * 4) begin
        other_errors++;
        $display("Fetch address %08h is unaligned or outside the program", imemory_addr);
      end
      check_value("imemory_wstrb", 32'(imemory_wstrb), 32'h0);
      check_value("imemory_wdata", imemory_wdata, 32'h0);
      check_value("imemory_instr", 32'(imemory_instr), 32'h1);
      wait_cnt = $urandom % 4;
      repeat (wait_cnt) @(posedge clock);
      #1;
      check_value("imemory_valid", 32'(imemory_valid), 32'h1); // Held through the wait.
      imemory_rdata = rom[imemory_addr[9:2]];
      imemory_ready = 1'b1;
      @(posedge clock); // Transfer edge.
      #1;
      imemory_ready = 1'b0;
      imemory_rdata = '0;
    end
  end

  function automatic addr_t reset_vector_exp();
    return 32'h0;
  endfunction

  // Data RAM; each store is compared with the next expected record.
  always begin : dmem_model
    int wait_cnt;
    @(posedge clock);
    #1;
    if (rst_n && dmemory_valid) begin
      check_value("dmemory_instr", 32'(dmemory_instr), 32'h0);
      wait_cnt = $urandom % 4;
      repeat (wait_cnt) @(posedge clock);
      #1;
      check_value("dmemory_valid", 32'(dmemory_valid), 32'h1); // Held through the wait.
      if (dmemory_wstrb == 4'hF) begin
        if (store_idx < store_count) begin
          check_value("dmemory_addr", dmemory_addr, testdata[2 + prog_len + 2 * store_idx]);
          check_value("dmemory_wdata", dmemory_wdata,
                      testdata[3 + prog_len + 2 * store_idx]);
        end else begin
          other_errors++;
          $display("Store to %08h beyond the expected store count", dmemory_addr);
        end
        store_idx++;
        ram[dmemory_addr[9:2]] = dmemory_wdata;
        if (dmemory_addr == 32'hFFC) begin
          done = 1'b1; // End marker store.
        end
      end else begin
        check_value("dmemory_wstrb", 32'(dmemory_wstrb), 32'h0);
        dmemory_rdata = ram[dmemory_addr[9:2]];
      end
      dmemory_ready = 1'b1;
      @(posedge clock);
      #1;
      dmemory_ready = 1'b0;
      dmemory_rdata = '0;
    end
  end

  initial begin
    void'($urandom(58926));
    rst_n = 1'b0;
    imemory_ready = 1'b0;
    imemory_rdata = '0;
    dmemory_ready = 1'b0;
    dmemory_rdata = '0;
    cycles = 0;
    store_idx = 0;
    value_errors = 0;
    other_errors = 0;
    done = 1'b0;
    first_fetch = 1'b1;
    $readmemh("tb/cpu_testdata.hex", testdata);
    prog_len = testdata[0];
    store_count = testdata[1];
    for (int i = 0; i < 256; i++) begin
      rom[i] = (i < prog_len) ? testdata[2 + i] : {8'(i), 8'(~i), 16'h0013};
      ram[i] = 32'hA500_0000 ^ (i * 32'h0101_0101);
    end
    limit = 40 * prog_len * 4;
    repeat (3) @(posedge clock);
    #1;
    rst_n = 1'b1;
    while (!done && cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    if (!done) begin
      other_errors++;
      $display("Timeout after %0d cycles, the program did not finish", cycles);
    end else if (store_idx != store_count) begin
      other_errors++;
      $display("Saw %0d stores but expected %0d", store_idx, store_count);
    end
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb/clock_gen.sv */
module clock_gen
(
  output logic clock
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
  end

  always #5 clock = ~clock; // 10 ns period.

endmodule

/* src/cpu.sv */
module cpu
#(
  parameter configure_pkg::addr_t reset_vector = configure_pkg::default_reset_vector
)
(
  input  logic                 clock,
  input  logic                 rst_n,
  output logic                 imemory_valid,
  output logic                 imemory_instr,
  output configure_pkg::addr_t imemory_addr,
  output configure_pkg::word_t imemory_wdata,
  output configure_pkg::strb_t imemory_wstrb,
  input  configure_pkg::word_t imemory_rdata,
  input  logic                 imemory_ready,
  output logic                 dmemory_valid,
  output logic                 dmemory_instr,
  output configure_pkg::addr_t dmemory_addr,
  output configure_pkg::word_t dmemory_wdata,
  output configure_pkg::strb_t dmemory_wstrb,
  input  configure_pkg::word_t dmemory_rdata,
  input  logic                 dmemory_ready
);
  import configure_pkg::*;
  import isa_pkg::*;

  logic fetch_req, fetch_done, mem_req, mem_done;
  logic pc_update, reg_write_en, is_mem;
  logic use_imm, use_pc, rd_write, is_load, is_store;
  reg_addr_t rs1, rs2, rd;
  alu_op_t alu_op;
  branch_t branch;
  addr_t pc, next_pc;
  word_t instr, imm, rs1_data, rs2_data;
  word_t operand_a, operand_b, result, link, load_data, write_data;

  assign is_mem = is_load | is_store;
  assign operand_a = use_pc ? pc : rs1_data;
  assign operand_b = use_imm ? imm : rs2_data;

  // Writeback source.
  assign write_data = is_load ? load_data : (branch == br_jump) ? link : result;

  sequencer sequencer_comp (
    .clock (clock), .rst_n (rst_n),
    .fetch_done (fetch_done), .mem_done (mem_done),
    .is_mem (is_mem), .rd_write (rd_write),
    .fetch_req (fetch_req), .mem_req (mem_req),
    .pc_update (pc_update), .reg_write_en (reg_write_en)
  );

  fetch_stage #(.reset_vector (reset_vector)) fetch_stage_comp (
    .clock (clock), .rst_n (rst_n),
    .fetch_req (fetch_req), .pc_update (pc_update), .next_pc (next_pc),
    .imemory_rdata (imemory_rdata), .imemory_ready (imemory_ready),
    .pc (pc), .instr (instr), .fetch_done (fetch_done),
    .imemory_valid (imemory_valid), .imemory_instr (imemory_instr),
    .imemory_addr (imemory_addr), .imemory_wdata (imemory_wdata),
    .imemory_wstrb (imemory_wstrb)
  );

  decoder decoder_comp (
    .instr (instr), .rs1 (rs1), .rs2 (rs2), .rd (rd), .imm (imm),
    .alu_op (alu_op), .branch (branch), .use_imm (use_imm), .use_pc (use_pc),
    .rd_write (rd_write), .is_load (is_load), .is_store (is_store)
  );

  register register_comp (
    .clock (clock), .rst_n (rst_n),
    .rs1 (rs1), .rs2 (rs2), .rd (rd),
    .write_en (reg_write_en), .write_data (write_data),
    .rs1_data (rs1_data), .rs2_data (rs2_data)
  );

  alu alu_comp (
    .operand_a (operand_a), .operand_b (operand_b),
    .rs1_data (rs1_data), .rs2_data (rs2_data), .pc (pc), .imm (imm),
    .alu_op (alu_op), .branch (branch),
    .result (result), .next_pc (next_pc), .link (link)
  );

  memory_stage memory_stage_comp (
    .clock (clock), .rst_n (rst_n),
    .mem_req (mem_req), .is_store (is_store),
    .addr (result), .store_data (rs2_data),
    .dmemory_rdata (dmemory_rdata), .dmemory_ready (dmemory_ready),
    .load_data (load_data), .mem_done (mem_done),
    .dmemory_valid (dmemory_valid), .dmemory_instr (dmemory_instr),
    .dmemory_addr (dmemory_addr), .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb)
  );

endmodule

/* src/memory_stage.sv */
module memory_stage
(
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 mem_req,
  input  logic                 is_store,
  input  configure_pkg::addr_t addr,
  input  configure_pkg::word_t store_data,
  input  configure_pkg::word_t dmemory_rdata,
  input  logic                 dmemory_ready,
  output configure_pkg::word_t load_data,
  output logic                 mem_done,
  output logic                 dmemory_valid,
  output logic                 dmemory_instr,
  output configure_pkg::addr_t dmemory_addr,
  output configure_pkg::word_t dmemory_wdata,
  output configure_pkg::strb_t dmemory_wstrb
);
  import configure_pkg::*;

  // Request held by the sequencer until ready.
  assign dmemory_valid = mem_req;
  assign dmemory_instr = 1'b0;
  assign dmemory_addr  = addr;
  assign dmemory_wdata = store_data;
  assign dmemory_wstrb = is_store ? strb_full : '0; // Zero marks a read.

  assign mem_done = dmemory_valid & dmemory_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      load_data <= '0;
    end else if (mem_done && !is_store) begin
      load_data <= dmemory_rdata;
    end
  end

endmodule

/* src/alu.sv */
module alu
(
  input  configure_pkg::word_t operand_a,
  input  configure_pkg::word_t operand_b,
  input  configure_pkg::word_t rs1_data,
  input  configure_pkg::word_t rs2_data,
  input  configure_pkg::word_t pc,
  input  configure_pkg::word_t imm,
  input  isa_pkg::alu_op_t     alu_op,
  input  isa_pkg::branch_t     branch,
  output configure_pkg::word_t result,
  output configure_pkg::addr_t next_pc,
  output configure_pkg::word_t link
);
  import isa_pkg::*;

  logic taken;

  always_comb begin
    case (alu_op)
      alu_sub: result = operand_a - operand_b;
      alu_and: result = operand_a & operand_b;
      alu_or:  result = operand_a | operand_b;
      alu_xor: result = operand_a ^ operand_b;
      alu_slt: result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      alu_sll: result = operand_a << operand_b[4:0];
      alu_srl: result = operand_a >> operand_b[4:0];
      alu_sra: result = $signed(operand_a) >>> operand_b[4:0];
      default: result = operand_a + operand_b;
    endcase
  end

  always_comb begin
    case (branch)
      br_eq:   taken = (rs1_data == rs2_data);
      br_ne:   taken = (rs1_data != rs2_data);
      br_lt:   taken = $signed(rs1_data) < $signed(rs2_data);
      br_ge:   taken = $signed(rs1_data) >= $signed(rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign link = pc + 32'd4;

  // Jumps take the adder sum, pc or rs1 plus imm.
  always_comb begin
    if (branch == br_jump) begin
      next_pc = {result[31:1], 1'b0};
    end else if (taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = link;
    end
  end

endmodule

/* src/register.sv */
module register
(
  input  logic                     clock,
  input  logic                     rst_n,
  input  configure_pkg::reg_addr_t rs1,
  input  configure_pkg::reg_addr_t rs2,
  input  configure_pkg::reg_addr_t rd,
  input  logic                     write_en,
  input  configure_pkg::word_t     write_data,
  output configure_pkg::word_t     rs1_data,
  output configure_pkg::word_t     rs2_data
);
  import configure_pkg::*;

  word_t regs [reg_count];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd != '0)) begin
      regs[rd] <= write_data; // x0 stays zero.
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

/* src/decoder.sv */
module decoder
(
  input  configure_pkg::word_t     instr,
  output configure_pkg::reg_addr_t rs1,
  output configure_pkg::reg_addr_t rs2,
  output configure_pkg::reg_addr_t rd,
  output configure_pkg::word_t     imm,
  output isa_pkg::alu_op_t         alu_op,
  output isa_pkg::branch_t         branch,
  output logic                     use_imm,
  output logic                     use_pc,
  output logic                     rd_write,
  output logic                     is_load,
  output logic                     is_store
);
  import configure_pkg::*;
  import isa_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  logic alt, funct7_ok;
  word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign alt       = instr[30]; // SUB and SRA.
  assign funct7_ok = !instr[31] && (instr[29:25] == 5'b0);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  always_comb begin
    rs1      = instr[19:15];
    imm      = '0;
    alu_op   = alu_add;
    branch   = br_none;
    use_imm  = 1'b0;
    use_pc   = 1'b0;
    rd_write = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    case (opcode)
      op_lui: begin
        rs1      = '0; // x0 plus the upper immediate.
        imm      = imm_u;
        use_imm  = 1'b1;
        rd_write = 1'b1;
      end
      op_auipc: begin
        imm      = imm_u;
        use_imm  = 1'b1;
        use_pc   = 1'b1;
        rd_write = 1'b1;
      end
      op_jal: begin
        imm      = imm_j;
        use_imm  = 1'b1;
        use_pc   = 1'b1;
        branch   = br_jump;
        rd_write = 1'b1;
      end
      op_jalr: begin
        imm      = imm_i;
        use_imm  = 1'b1;
        branch   = (funct3 == f3_add) ? br_jump : br_none;
        rd_write = (funct3 == f3_add);
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          f3_beq:  branch = br_eq;
          f3_bne:  branch = br_ne;
          f3_blt:  branch = br_lt;
          f3_bge:  branch = br_ge;
          default: branch = br_none;
        endcase
      end
      op_load: begin
        imm      = imm_i;
        use_imm  = 1'b1;
        is_load  = (funct3 == f3_word);
        rd_write = (funct3 == f3_word);
      end
      op_store: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = (funct3 == f3_word);
      end
      op_imm: begin
        imm      = imm_i;
        use_imm  = 1'b1;
        rd_write = 1'b1;
        case (funct3)
          f3_add:  alu_op = alu_add;
          f3_slt:  alu_op = alu_slt;
          f3_xor:  alu_op = alu_xor;
          f3_or:   alu_op = alu_or;
          f3_and:  alu_op = alu_and;
          default: rd_write = 1'b0;
        endcase
      end
      op_reg: begin
        rd_write = funct7_ok;
        case (funct3)
          f3_add: alu_op = alt ? alu_sub : alu_add;
          f3_srl: alu_op = alt ? alu_sra : alu_srl;
          f3_sll: begin
            alu_op   = alu_sll;
            rd_write = funct7_ok && !alt;
          end
          f3_slt: begin
            alu_op   = alu_slt;
            rd_write = funct7_ok && !alt;
          end
          f3_xor: begin
            alu_op   = alu_xor;
            rd_write = funct7_ok && !alt;
          end
          f3_or: begin
            alu_op   = alu_or;
            rd_write = funct7_ok && !alt;
          end
          default: begin
            alu_op   = alu_and;
            rd_write = funct7_ok && !alt;
          end
        endcase
      end
      default: begin
        rd_write = 1'b0; // Unknown opcode runs as a NOP.
      end
    endcase
  end

endmodule

/* src/fetch_stage.sv */
module fetch_stage
#(
  parameter configure_pkg::addr_t reset_vector = configure_pkg::default_reset_vector
)
(
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 fetch_req,
  input  logic                 pc_update,
  input  configure_pkg::addr_t next_pc,
  input  configure_pkg::word_t imemory_rdata,
  input  logic                 imemory_ready,
  output configure_pkg::addr_t pc,
  output configure_pkg::word_t instr,
  output logic                 fetch_done,
  output logic                 imemory_valid,
  output logic                 imemory_instr,
  output configure_pkg::addr_t imemory_addr,
  output configure_pkg::word_t imemory_wdata,
  output configure_pkg::strb_t imemory_wstrb
);

  // Instruction port is read only.
  assign imemory_valid = fetch_req;
  assign imemory_instr = 1'b1;
  assign imemory_addr  = pc;
  assign imemory_wdata = '0;
  assign imemory_wstrb = '0;

  assign fetch_done = imemory_valid & imemory_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_vector;
    end else if (pc_update) begin
      pc <= next_pc;
    end
  end

  // Held until the next fetch completes.
  always_ff @(posedge clock) begin
    if (fetch_done) begin
      instr <= imemory_rdata;
    end
  end

endmodule

/* src/sequencer.sv */
module sequencer
(
  input  logic clock,
  input  logic rst_n,
  input  logic fetch_done,
  input  logic mem_done,
  input  logic is_mem,
  input  logic rd_write,
  output logic fetch_req,
  output logic mem_req,
  output logic pc_update,
  output logic reg_write_en
);
  import isa_pkg::*;

  seq_state_t state, state_next;

  always_comb begin
    state_next = state;
    case (state)
      st_fetch: begin
        if (fetch_done) begin
          state_next = st_execute;
        end
      end
      st_execute: begin
        state_next = is_mem ? st_memory : st_writeback;
      end
      st_memory: begin
        if (mem_done) begin
          state_next = st_writeback;
        end
      end
      default: begin
        state_next = st_fetch;
      end
    endcase
  end

  // Requests are registered from the next state, so a bus request
  // is up for the whole of its state and stays low during reset.
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_fetch;
      fetch_req <= 1'b0;
      mem_req   <= 1'b0;
    end else begin
      state     <= state_next;
      fetch_req <= (state_next == st_fetch);
      mem_req   <= (state_next == st_memory);
    end
  end

  assign pc_update    = (state == st_writeback);
  assign reg_write_en = pc_update & rd_write; // Only when rd is marked.

endmodule

/* src/isa_pkg.sv */
package isa_pkg;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_t;

  typedef logic [2:0] funct3_t;

  localparam funct3_t f3_add  = 3'b000; // ADD, SUB, ADDI, JALR.
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_srl  = 3'b101; // SRL and SRA.
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_word = 3'b010; // LW and SW.

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl, alu_sra
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_jump
  } branch_t;

  typedef enum logic [1:0] {
    st_fetch, st_execute, st_memory, st_writeback
  } seq_state_t;

endpackage

/* src/configure_pkg.sv */
package configure_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [xlen-1:0] addr_t;
  typedef logic [xlen/8-1:0] strb_t;
  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

  // Start address after reset.
  localparam addr_t default_reset_vector = 32'h0000_0000;

  // Full-word write on the data bus.
  localparam strb_t strb_full = 4'hF;

endpackage
